//--- icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts
   import icache_cfg_pkg::*;
   import icache_ctrl_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  icache_state_e state_i,
   input  logic          fetch_req_i,
   input  logic          fetch_gnt_i,
   input  logic          fetch_rvalid_i,
   input  logic          refill_req_i,
   input  fetch_addr_t   refill_addr_i,
   input  logic          refill_gnt_i
);

   // Fetches granted but not yet answered
   int outstanding_q;

   // Assertion failures so far
   int fail_cnt = 0;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         outstanding_q <= 0;
      else
         outstanding_q <= outstanding_q + int'(fetch_req_i && fetch_gnt_i)
                          - int'(fetch_rvalid_i);
   end

   refill_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_i && !refill_gnt_i |=> refill_req_i && $stable(refill_addr_i))
   else
   begin
      $error("refill request dropped or address changed before grant");
      fail_cnt++;
   end

   // No grant inside a flush, nor in the cycle that starts one
   no_gnt_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
      (state_i == FLUSH_ALL || state_i == FLUSH_SET)
         |-> !fetch_gnt_i && !$past(fetch_gnt_i))
   else
   begin
      $error("fetch granted during or into a flush");
      fail_cnt++;
   end

   rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_i |-> outstanding_q > 0)
   else
   begin
      $error("fetch rvalid without a granted fetch");
      fail_cnt++;
   end

endmodule

//--- icache_cfg_pkg.sv
package icache_cfg_pkg;

   ////////////////////
   // Fetch port widths
   ////////////////////

   parameter int FETCH_ADDR_W = 32;
   parameter int FETCH_DATA_W = 32;

   // One refill beat carries a whole line
   parameter int LINE_W = 128;

   // Byte offset inside a line, the word select sits in its top two bits
   parameter int OFFSET_W = 4;

   ////////////////////
   // Types
   ////////////////////

   typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;

   typedef logic [FETCH_DATA_W-1:0] fetch_word_t;

   // Line seen as an array of fetch words, word 0 at the lowest address
   typedef logic [LINE_W/FETCH_DATA_W-1:0][FETCH_DATA_W-1:0] refill_line_t;

endpackage

//--- icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
   import icache_cfg_pkg::*;
   import icache_ctrl_pkg::*;
#(
   parameter int NB_WAYS   = 4,
   parameter int SET_ID_W  = 4,
   localparam int TAG_W    = FETCH_ADDR_W - SET_ID_W - OFFSET_W
)
(
   input  logic                clk,
   input  logic                rst_n,

   input  logic                fetch_req_i,
   input  fetch_addr_t         fetch_addr_i,
   input  logic                bypass_icache_i,
   input  logic                flush_icache_i,
   input  logic                flush_set_id_req_i,
   input  fetch_addr_t         flush_set_id_addr_i,
   input  logic                refill_gnt_i,
   input  logic                refill_r_valid_i,
   input  refill_line_t        refill_r_data_i,
   input  logic                hit_i,
   input  refill_line_t        hit_line_i,
   input  logic [NB_WAYS-1:0]  victim_oh_i,

   output logic                fetch_gnt_o,
   output logic                fetch_rvalid_o,
   output fetch_word_t         fetch_rdata_o,
   output logic                refill_req_o,
   output fetch_addr_t         refill_addr_o,
   output logic                cache_is_bypassed_o,
   output logic                cache_is_flushed_o,
   output logic                flush_set_id_ack_o,

   // Way control
   output logic                way_rd_en_o,
   output logic [SET_ID_W-1:0] way_rd_set_o,
   output logic [TAG_W-1:0]    lookup_tag_o,
   output logic [NB_WAYS-1:0]  way_wr_en_o,
   output logic                way_inv_en_o,
   output logic [SET_ID_W-1:0] way_wr_set_o,
   output logic [TAG_W-1:0]    way_wr_tag_o,
   output refill_line_t        way_wr_line_o,
   output logic                lfsr_step_o
);

   icache_state_e       state_q, state_d;
   fetch_addr_t         addr_q;
   logic [SET_ID_W-1:0] flush_cnt_q, flush_cnt_d;
   logic [NB_WAYS-1:0]  victim_q;
   logic                save_victim;
   logic [1:0]          word_sel;

   // Fields of the held fetch address
   assign word_sel      = addr_q[OFFSET_W-1 -: 2];
   assign lookup_tag_o  = addr_q[FETCH_ADDR_W-1 -: TAG_W];
   assign way_wr_tag_o  = addr_q[FETCH_ADDR_W-1 -: TAG_W];
   assign refill_addr_o = addr_q;

   // Ways are indexed by the incoming address so data is ready next cycle
   assign way_rd_set_o  = fetch_addr_i[OFFSET_W +: SET_ID_W];
   assign way_wr_line_o = refill_r_data_i;

   ////////////////////
   // FSM
   ////////////////////

   always_comb
   begin
      state_d             = state_q;
      flush_cnt_d         = flush_cnt_q;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      fetch_rdata_o       = refill_r_data_i[word_sel];
      refill_req_o        = 1'b0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_id_ack_o  = 1'b0;
      way_rd_en_o         = 1'b0;
      way_wr_en_o         = '0;
      way_inv_en_o        = 1'b0;
      way_wr_set_o        = addr_q[OFFSET_W +: SET_ID_W];
      save_victim         = 1'b0;
      lfsr_step_o         = 1'b0;

      case (state_q)
         DISABLED:
         begin
            flush_set_id_ack_o  = 1'b1;
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_cnt_d         = '0;
            if (bypass_icache_i)
            begin
               fetch_gnt_o = fetch_req_i;
               if (fetch_req_i)
                  state_d = BYPASS_REFILL;
            end
            else
            begin
               state_d = FLUSH_ALL;
            end
         end

         BYPASS_REFILL:
         begin
            flush_set_id_ack_o  = 1'b1;
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            refill_req_o        = 1'b1;
            if (refill_gnt_i)
               state_d = BYPASS_WAIT;
         end

         BYPASS_WAIT:
         begin
            flush_set_id_ack_o  = 1'b1;
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            fetch_rvalid_o      = refill_r_valid_i;
            if (refill_r_valid_i)
               state_d = DISABLED;
         end

         // One set per cycle, all ways at once
         FLUSH_ALL:
         begin
            flush_set_id_ack_o = 1'b1;
            way_inv_en_o       = 1'b1;
            way_wr_set_o       = flush_cnt_q;
            if (flush_cnt_q == {SET_ID_W{1'b1}})
            begin
               cache_is_flushed_o = 1'b1;
               flush_cnt_d        = '0;
               state_d            = IDLE;
            end
            else
            begin
               flush_cnt_d = flush_cnt_q + 1'b1;
            end
         end

         FLUSH_SET:
         begin
            flush_set_id_ack_o = 1'b1;
            way_inv_en_o       = 1'b1;
            way_wr_set_o       = flush_set_id_addr_i[OFFSET_W +: SET_ID_W];
            state_d            = IDLE;
         end

         IDLE:
         begin
            if (bypass_icache_i)
               state_d = DISABLED;
            else if (flush_icache_i)
               state_d = FLUSH_ALL;
            else if (flush_set_id_req_i)
               state_d = FLUSH_SET;
            else
            begin
               fetch_gnt_o = fetch_req_i;
               way_rd_en_o = fetch_req_i;
               if (fetch_req_i)
                  state_d = TAG_LOOKUP;
            end
         end

         TAG_LOOKUP:
         begin
            if (hit_i)
            begin
               // Back to back hits, the next fetch is taken here
               fetch_rvalid_o = 1'b1;
               fetch_rdata_o  = hit_line_i[word_sel];
               fetch_gnt_o    = fetch_req_i;
               way_rd_en_o    = fetch_req_i;
               if (!fetch_req_i)
                  state_d = IDLE;
            end
            else
            begin
               refill_req_o = 1'b1;
               save_victim  = 1'b1;
               // Selector only advances when every way was valid
               lfsr_step_o  = 1'b1;
               if (refill_gnt_i)
                  state_d = WAIT_REFILL_DONE;
               else
                  state_d = WAIT_REFILL_GNT;
            end
         end

         WAIT_REFILL_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = WAIT_REFILL_DONE;
         end

         WAIT_REFILL_DONE:
         begin
            fetch_rvalid_o = refill_r_valid_i;
            way_wr_en_o    = victim_q & {NB_WAYS{refill_r_valid_i}};
            if (refill_r_valid_i)
               state_d = IDLE;
         end

         default:
         begin
            state_d = DISABLED;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= DISABLED;
         flush_cnt_q <= '0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
      end
   end

   // Held fetch address and the way picked for the refill
   always_ff @(posedge clk)
   begin
      if (fetch_req_i && fetch_gnt_o)
         addr_q <= fetch_addr_i;
      if (save_victim)
         victim_q <= victim_oh_i;
   end

endmodule

//--- icache_ctrl_pkg.sv
package icache_ctrl_pkg;

   // Controller FSM states
   typedef enum logic [3:0] {
      DISABLED,
      BYPASS_REFILL,
      BYPASS_WAIT,
      FLUSH_ALL,
      FLUSH_SET,
      IDLE,
      TAG_LOOKUP,
      WAIT_REFILL_GNT,
      WAIT_REFILL_DONE
   } icache_state_e;

   // Replacement LFSR, the seed must not be zero
   parameter int LFSR_W = 8;
   parameter logic [LFSR_W-1:0] LFSR_SEED = 8'hA5;

endpackage

//--- icache_tb.sv
`timescale 1ns/1ps

module icache_tb
   import icache_cfg_pkg::*;
();

   localparam int          FLUSH_CYCLES = 16;
   localparam int          WAIT_LIMIT   = 100;
   localparam fetch_word_t WORD_KEY     = 32'h5A5A_C3C3;

   typedef enum {CMD_FETCH, CMD_BYPASS_FETCH, CMD_FLUSH, CMD_FLUSH_SET, CMD_ENABLE} cmd_e;

   // A negative refill count means the count is not checked
   typedef struct {
      cmd_e        cmd;
      fetch_addr_t addr;
      int          exp_refills;
   } entry_t;

   logic         clk;
   logic         rst_n;
   logic         fetch_req_i;
   fetch_addr_t  fetch_addr_i;
   logic         fetch_gnt_o;
   logic         fetch_rvalid_o;
   fetch_word_t  fetch_rdata_o;
   logic         refill_req_o;
   fetch_addr_t  refill_addr_o;
   logic         refill_gnt_i;
   logic         refill_r_valid_i;
   refill_line_t refill_r_data_i;
   logic         bypass_icache_i;
   logic         flush_icache_i;
   logic         flush_set_id_req_i;
   fetch_addr_t  flush_set_id_addr_i;
   logic         flush_set_id_ack_o;
   logic         cache_is_bypassed_o;
   logic         cache_is_flushed_o;

   entry_t       stim_q[$];
   logic         stim_ready = 1'b0;
   logic [31:0]  rng_q = 32'd33191;
   int           refill_cnt = 0;
   int           data_errors = 0;
   int           refill_errors = 0;
   int           other_errors = 0;
   int           assert_errors = 0;

   icache_tb_clk i_icache_tb_clk (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   icache_top i_icache_top (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .refill_req_o        (refill_req_o),
      .refill_addr_o       (refill_addr_o),
      .refill_gnt_i        (refill_gnt_i),
      .refill_r_valid_i    (refill_r_valid_i),
      .refill_r_data_i     (refill_r_data_i),
      .bypass_icache_i     (bypass_icache_i),
      .flush_icache_i      (flush_icache_i),
      .flush_set_id_req_i  (flush_set_id_req_i),
      .flush_set_id_addr_i (flush_set_id_addr_i),
      .flush_set_id_ack_o  (flush_set_id_ack_o),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o)
   );

   bind icache_ctrl icache_asserts i_icache_asserts (
      .clk            (clk),
      .rst_n          (rst_n),
      .state_i        (state_q),
      .fetch_req_i    (fetch_req_i),
      .fetch_gnt_i    (fetch_gnt_o),
      .fetch_rvalid_i (fetch_rvalid_o),
      .refill_req_i   (refill_req_o),
      .refill_addr_i  (refill_addr_o),
      .refill_gnt_i   (refill_gnt_i)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Each word is its own byte address XOR a key
   function automatic fetch_word_t expected_word(input fetch_addr_t addr);
      return {addr[31:2], 2'b00} ^ WORD_KEY;
   endfunction

   function automatic refill_line_t memory_line(input fetch_addr_t addr);
      refill_line_t line;
      for (int k = 0; k < 4; k++)
         line[k] = expected_word({addr[31:4], 4'h0} + 32'(4 * k));
      return line;
   endfunction

   task automatic push_entry(input cmd_e cmd, input fetch_addr_t addr, input int exp_refills);
      entry_t e;
      e.cmd         = cmd;
      e.addr        = addr;
      e.exp_refills = exp_refills;
      stim_q.push_back(e);
   endtask

   ////////////////////
   // Refill memory
   ////////////////////

   initial
   begin : refill_memory
      int          gnt_delay;
      int          data_delay;
      fetch_addr_t line_addr;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      forever
      begin
         @(posedge clk);
         #2;
         if (refill_req_o)
         begin
            rng_q     = xorshift(rng_q);
            gnt_delay = rng_q % 4;
            rng_q     = xorshift(rng_q);
            data_delay = rng_q % 3 + 1;
            repeat (gnt_delay)
            begin
               @(posedge clk);
               #2;
            end
            refill_gnt_i = 1'b1;
            line_addr    = refill_addr_o;
            refill_cnt++;
            repeat (data_delay)
            begin
               @(posedge clk);
               #2;
               refill_gnt_i = 1'b0;
            end
            refill_r_valid_i = 1'b1;
            refill_r_data_i  = memory_line(line_addr);
            @(posedge clk);
            #2;
            refill_r_valid_i = 1'b0;
         end
      end
   end

   ////////////////////
   // Command tasks
   ////////////////////

   task automatic run_fetch(input fetch_addr_t addr, input int exp_refills, input logic bypass);
      int          start_cnt;
      int          wait_cnt;
      fetch_word_t exp;
      start_cnt    = refill_cnt;
      exp          = expected_word(addr);
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr;
      wait_cnt     = 0;
      @(negedge clk);
      while (!fetch_gnt_o && wait_cnt < WAIT_LIMIT)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!fetch_gnt_o)
      begin
         other_errors++;
         $display("Fetch at %h was never granted (time %0t)", addr, $time);
         fetch_req_i = 1'b0;
         return;
      end
      if (cache_is_bypassed_o !== bypass)
      begin
         other_errors++;
         $display("** Error at %0t: cache_is_bypassed_o = %b, expected %b",
                  $time, cache_is_bypassed_o, bypass);
      end
      @(posedge clk);
      #2;
      fetch_req_i = 1'b0;
      wait_cnt    = 0;
      @(negedge clk);
      while (!fetch_rvalid_o && wait_cnt < WAIT_LIMIT)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!fetch_rvalid_o)
      begin
         other_errors++;
         $display("Fetch at %h never returned data (time %0t)", addr, $time);
         return;
      end
      if (fetch_rdata_o !== exp)
      begin
         data_errors++;
         $display("** Error at %0t: fetch_rdata_o = %h, expected %h (addr %h)",
                  $time, fetch_rdata_o, exp, addr);
      end
      if (exp_refills >= 0 && refill_cnt - start_cnt != exp_refills)
      begin
         refill_errors++;
         $display("** Error at %0t: refill count change = %0d, expected %0d (addr %h)",
                  $time, refill_cnt - start_cnt, exp_refills, addr);
      end
   endtask

   // Follows a whole-cache flush until the flushed pulse on its last cycle
   task automatic wait_flush_done();
      int low_cnt;
      int wait_cnt;
      low_cnt  = 0;
      wait_cnt = 0;
      @(negedge clk);
      while (cache_is_flushed_o && wait_cnt < WAIT_LIMIT)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      while (!cache_is_flushed_o && low_cnt < WAIT_LIMIT)
      begin
         @(negedge clk);
         low_cnt++;
      end
      if (!cache_is_flushed_o)
      begin
         other_errors++;
         $display("Full flush never finished (time %0t)", $time);
      end
      else if (low_cnt != FLUSH_CYCLES - 1)
      begin
         other_errors++;
         $display("** Error at %0t: flush cycles = %0d, expected %0d",
                  $time, low_cnt + 1, FLUSH_CYCLES);
      end
      if (cache_is_bypassed_o !== 1'b0)
      begin
         other_errors++;
         $display("** Error at %0t: cache_is_bypassed_o = %b, expected 0",
                  $time, cache_is_bypassed_o);
      end
   endtask

   task automatic run_flush_set(input fetch_addr_t addr);
      flush_set_id_req_i  = 1'b1;
      flush_set_id_addr_i = addr;
      @(posedge clk);
      #2;
      flush_set_id_req_i = 1'b0;
      @(negedge clk);
      if (flush_set_id_ack_o !== 1'b1)
      begin
         other_errors++;
         $display("** Error at %0t: flush_set_id_ack_o = %b, expected 1",
                  $time, flush_set_id_ack_o);
      end
   endtask

   ////////////////////
   // Stimulus table
   ////////////////////

   task automatic build_table();
      // Bypass
      push_entry(CMD_BYPASS_FETCH, 32'h0000_1000, 1);
      push_entry(CMD_BYPASS_FETCH, 32'h0000_2004, 1);
      push_entry(CMD_BYPASS_FETCH, 32'h0000_300C, 1);
      // Enable, then fill sets 0 and 1
      push_entry(CMD_ENABLE, 32'h0, 0);
      push_entry(CMD_FETCH, 32'h0000_1000, 1);
      push_entry(CMD_FETCH, 32'h0000_1004, 0);
      push_entry(CMD_FETCH, 32'h0000_1008, 0);
      push_entry(CMD_FETCH, 32'h0000_100C, 0);
      push_entry(CMD_FETCH, 32'h0000_2010, 1);
      push_entry(CMD_FETCH, 32'h0000_2014, 0);
      push_entry(CMD_FETCH, 32'h0000_3000, 1);
      push_entry(CMD_FETCH, 32'h0000_3008, 0);
      push_entry(CMD_FETCH, 32'h0000_1000, 0);
      // Set 0 is dropped, set 1 survives
      push_entry(CMD_FLUSH_SET, 32'h0000_0000, 0);
      push_entry(CMD_FETCH, 32'h0000_1004, 1);
      push_entry(CMD_FETCH, 32'h0000_2018, 0);
      push_entry(CMD_FETCH, 32'h0000_3000, 1);
      // Everything refills after a full flush
      push_entry(CMD_FLUSH, 32'h0, 0);
      push_entry(CMD_FETCH, 32'h0000_2010, 1);
      push_entry(CMD_FETCH, 32'h0000_1000, 1);
      push_entry(CMD_FETCH, 32'h0000_300C, 1);
      // Six lines into set 5
      for (int i = 1; i <= 6; i++)
         push_entry(CMD_FETCH, 32'h0000_0050 + 32'(i << 12), -1);
      for (int i = 1; i <= 6; i++)
         push_entry(CMD_FETCH, 32'h0000_0050 + 32'(i << 12) + 32'((i % 4) * 4), -1);
      stim_ready = 1'b1;
   endtask

   ////////////////////
   // Main flow
   ////////////////////

   initial
   begin
      fetch_req_i         = 1'b0;
      fetch_addr_i        = '0;
      bypass_icache_i     = 1'b1;
      flush_icache_i      = 1'b0;
      flush_set_id_req_i  = 1'b0;
      flush_set_id_addr_i = '0;
      build_table();
      @(posedge rst_n);
      @(posedge clk);
      #2;
      foreach (stim_q[i])
      begin
         case (stim_q[i].cmd)
            CMD_BYPASS_FETCH:
            begin
               bypass_icache_i = 1'b1;
               run_fetch(stim_q[i].addr, stim_q[i].exp_refills, 1'b1);
            end
            CMD_FETCH:
               run_fetch(stim_q[i].addr, stim_q[i].exp_refills, 1'b0);
            CMD_ENABLE:
            begin
               bypass_icache_i = 1'b0;
               wait_flush_done();
            end
            CMD_FLUSH:
            begin
               flush_icache_i = 1'b1;
               @(posedge clk);
               #2;
               flush_icache_i = 1'b0;
               wait_flush_done();
            end
            CMD_FLUSH_SET:
               run_flush_set(stim_q[i].addr);
         endcase
         @(posedge clk);
         #2;
      end
      assert_errors = i_icache_top.i_icache_ctrl.i_icache_asserts.fail_cnt;
      $display("Errors: %0d data, %0d refill count, %0d other, %0d assertion",
               data_errors, refill_errors, other_errors, assert_errors);
      if (data_errors + refill_errors + other_errors + assert_errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // Watchdog sized from the table length
   initial
   begin : watchdog
      int limit;
      wait (stim_ready);
      limit = stim_q.size() * 12 + FLUSH_CYCLES + 50;
      repeat (limit) @(posedge clk);
      assert_errors = i_icache_top.i_icache_ctrl.i_icache_asserts.fail_cnt;
      $display("Watchdog expired after %0d cycles, the run did not finish", limit);
      $display("Errors: %0d data, %0d refill count, %0d other, %0d assertion",
               data_errors, refill_errors, other_errors + 1, assert_errors);
      $display("Result: FAILED");
      $finish;
   end

endmodule

//--- icache_tb_clk.sv
`timescale 1ns/1ps

module icache_tb_clk #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 5
)
(
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o   = 1'b0;
      rst_n_o = 1'b0;
      forever #(PERIOD_NS/2) clk_o = ~clk_o;
   end

   // Release reset shortly after a rising edge
   initial
   begin
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2 rst_n_o = 1'b1;
   end

endmodule

//--- icache_top.sv
`timescale 1ns/1ps

module icache_top
   import icache_cfg_pkg::*;
#(
   parameter int NB_WAYS   = 4,
   parameter int SET_ID_W  = 4,
   localparam int TAG_W    = FETCH_ADDR_W - SET_ID_W - OFFSET_W
)
(
   input  logic         clk,
   input  logic         rst_n,

   // Fetch port
   input  logic         fetch_req_i,
   input  fetch_addr_t  fetch_addr_i,
   output logic         fetch_gnt_o,
   output logic         fetch_rvalid_o,
   output fetch_word_t  fetch_rdata_o,

   // Refill port
   output logic         refill_req_o,
   output fetch_addr_t  refill_addr_o,
   input  logic         refill_gnt_i,
   input  logic         refill_r_valid_i,
   input  refill_line_t refill_r_data_i,

   // Control and status
   input  logic         bypass_icache_i,
   input  logic         flush_icache_i,
   input  logic         flush_set_id_req_i,
   input  fetch_addr_t  flush_set_id_addr_i,
   output logic         flush_set_id_ack_o,
   output logic         cache_is_bypassed_o,
   output logic         cache_is_flushed_o
);

   logic                way_rd_en;
   logic [SET_ID_W-1:0] way_rd_set;
   logic [TAG_W-1:0]    lookup_tag;
   logic [NB_WAYS-1:0]  way_wr_en;
   logic                way_inv_en;
   logic [SET_ID_W-1:0] way_wr_set;
   logic [TAG_W-1:0]    way_wr_tag;
   refill_line_t        way_wr_line;

   logic [NB_WAYS-1:0]  way_valid;
   logic [NB_WAYS-1:0]  way_match;
   refill_line_t        way_line [NB_WAYS];

   logic                hit;
   refill_line_t        hit_line;
   logic [NB_WAYS-1:0]  victim_oh;
   logic                lfsr_step;

   icache_ctrl #(
      .NB_WAYS  (NB_WAYS),
      .SET_ID_W (SET_ID_W)
   ) i_icache_ctrl (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .bypass_icache_i     (bypass_icache_i),
      .flush_icache_i      (flush_icache_i),
      .flush_set_id_req_i  (flush_set_id_req_i),
      .flush_set_id_addr_i (flush_set_id_addr_i),
      .refill_gnt_i        (refill_gnt_i),
      .refill_r_valid_i    (refill_r_valid_i),
      .refill_r_data_i     (refill_r_data_i),
      .hit_i               (hit),
      .hit_line_i          (hit_line),
      .victim_oh_i         (victim_oh),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .refill_req_o        (refill_req_o),
      .refill_addr_o       (refill_addr_o),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .flush_set_id_ack_o  (flush_set_id_ack_o),
      .way_rd_en_o         (way_rd_en),
      .way_rd_set_o        (way_rd_set),
      .lookup_tag_o        (lookup_tag),
      .way_wr_en_o         (way_wr_en),
      .way_inv_en_o        (way_inv_en),
      .way_wr_set_o        (way_wr_set),
      .way_wr_tag_o        (way_wr_tag),
      .way_wr_line_o       (way_wr_line),
      .lfsr_step_o         (lfsr_step)
   );

   // One storage way per index, all sharing the read and write index
   for (genvar g = 0; g < NB_WAYS; g++)
   begin : gen_way
      icache_way #(
         .SET_ID_W (SET_ID_W)
      ) i_icache_way (
         .clk          (clk),
         .rst_n        (rst_n),
         .rd_en_i      (way_rd_en),
         .rd_set_i     (way_rd_set),
         .lookup_tag_i (lookup_tag),
         .wr_en_i      (way_wr_en[g]),
         .inv_en_i     (way_inv_en),
         .wr_set_i     (way_wr_set),
         .wr_tag_i     (way_wr_tag),
         .wr_line_i    (way_wr_line),
         .valid_o      (way_valid[g]),
         .match_o      (way_match[g]),
         .line_o       (way_line[g])
      );
   end

   icache_way_select #(
      .NB_WAYS (NB_WAYS)
   ) i_icache_way_select (
      .clk         (clk),
      .rst_n       (rst_n),
      .valid_i     (way_valid),
      .match_i     (way_match),
      .lines_i     (way_line),
      .lfsr_step_i (lfsr_step),
      .hit_o       (hit),
      .hit_line_o  (hit_line),
      .victim_oh_o (victim_oh)
   );

endmodule

//--- icache_way.sv
`timescale 1ns/1ps

module icache_way
   import icache_cfg_pkg::*;
#(
   parameter int SET_ID_W  = 4,
   localparam int TAG_W    = FETCH_ADDR_W - SET_ID_W - OFFSET_W,
   localparam int NB_SETS  = 2**SET_ID_W
)
(
   input  logic                clk,
   input  logic                rst_n,

   input  logic                rd_en_i,
   input  logic [SET_ID_W-1:0] rd_set_i,
   input  logic [TAG_W-1:0]    lookup_tag_i,

   input  logic                wr_en_i,
   input  logic                inv_en_i,
   input  logic [SET_ID_W-1:0] wr_set_i,
   input  logic [TAG_W-1:0]    wr_tag_i,
   input  refill_line_t        wr_line_i,

   output logic                valid_o,
   output logic                match_o,
   output refill_line_t        line_o
);

   logic [NB_SETS-1:0] valid_q;
   logic [TAG_W-1:0]   tag_mem [NB_SETS];
   refill_line_t       line_mem [NB_SETS];

   logic               valid_rd_q;
   logic [TAG_W-1:0]   tag_rd_q;

   // Valid bits, invalidate wins over a write to the same set
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q    <= '0;
         valid_rd_q <= 1'b0;
      end
      else
      begin
         if (inv_en_i)
            valid_q[wr_set_i] <= 1'b0;
         else if (wr_en_i)
            valid_q[wr_set_i] <= 1'b1;
         if (rd_en_i)
            valid_rd_q <= valid_q[rd_set_i];
      end
   end

   // Tag and line storage with registered read
   always_ff @(posedge clk)
   begin
      if (wr_en_i)
      begin
         tag_mem[wr_set_i]  <= wr_tag_i;
         line_mem[wr_set_i] <= wr_line_i;
      end
      if (rd_en_i)
      begin
         tag_rd_q <= tag_mem[rd_set_i];
         line_o   <= line_mem[rd_set_i];
      end
   end

   assign valid_o = valid_rd_q;
   assign match_o = valid_rd_q && (tag_rd_q == lookup_tag_i);

endmodule

//--- icache_way_select.sv
`timescale 1ns/1ps

module icache_way_select
   import icache_cfg_pkg::*;
   import icache_ctrl_pkg::*;
#(
   parameter int NB_WAYS    = 4,
   localparam int WAY_IDX_W = $clog2(NB_WAYS)
)
(
   input  logic               clk,
   input  logic               rst_n,

   input  logic [NB_WAYS-1:0] valid_i,
   input  logic [NB_WAYS-1:0] match_i,
   input  refill_line_t       lines_i [NB_WAYS],
   input  logic               lfsr_step_i,

   output logic               hit_o,
   output refill_line_t       hit_line_o,
   output logic [NB_WAYS-1:0] victim_oh_o
);

   // x^8 + x^6 + x^5 + x^4 + 1
   localparam logic [LFSR_W-1:0] LFSR_TAPS = 8'hB8;

   logic [WAY_IDX_W-1:0] hit_idx;
   logic [WAY_IDX_W-1:0] free_idx;
   logic                 all_valid;
   logic [NB_WAYS-1:0]   free_oh;
   logic [NB_WAYS-1:0]   rand_oh;
   logic [LFSR_W-1:0]    lfsr_q;
   logic                 lfsr_fb;

   ////////////////////
   // Hit and free way
   ////////////////////

   // Highest index wins in both searches
   always_comb
   begin
      hit_idx  = '0;
      free_idx = '0;
      for (int i = 0; i < NB_WAYS; i++)
      begin
         if (match_i[i])
            hit_idx = WAY_IDX_W'(i);
         if (!valid_i[i])
            free_idx = WAY_IDX_W'(i);
      end
   end

   assign hit_o      = |match_i;
   assign hit_line_o = lines_i[hit_idx];
   assign all_valid  = &valid_i;
   assign free_oh    = {{(NB_WAYS-1){1'b0}}, 1'b1} << free_idx;

   ////////////////////
   // Random victim
   ////////////////////

   assign lfsr_fb     = ^(lfsr_q & LFSR_TAPS);
   assign rand_oh     = {{(NB_WAYS-1){1'b0}}, 1'b1} << lfsr_q[WAY_IDX_W-1:0];
   assign victim_oh_o = all_valid ? rand_oh : free_oh;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= LFSR_SEED;
      else if (lfsr_step_i && all_valid)
         lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_fb};
   end

endmodule

//--- vlog.f
icache_cfg_pkg.sv
icache_ctrl_pkg.sv
icache_way.sv
icache_way_select.sv
icache_ctrl.sv
icache_top.sv
icache_asserts.sv
icache_tb_clk.sv
icache_tb.sv
